// File: common/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    // --------------------------------------------------
    // Matrix geometry
    // --------------------------------------------------
    localparam int MAX_DIM = 5;                 // Largest row or column count

    typedef logic [2:0]         dim_t;          // Row or column count, or an index
    typedef logic signed [15:0] elem_t;
    typedef logic [1:0]         slot_t;

    // Zero dimensions mark an empty slot
    typedef struct packed {
        dim_t m;
        dim_t n;
    } mat_dim_t;

    typedef struct packed {
        slot_t slot;
        dim_t  row;
        dim_t  col;
    } mat_addr_t;

    typedef struct packed {
        mat_addr_t addr;
        elem_t     data;
        logic      we;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: common/calc_pkg.sv
`default_nettype none

package calc_pkg;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_mul = 3'd2,
        op_sca = 3'd3,  // Scalar multiply
        op_tra = 3'd4   // Transpose
    } opcode_t;

    // --------------------------------------------------
    // ASCII characters used by the printer
    // --------------------------------------------------
    localparam logic [7:0] CH_OPEN  = 8'h5B;   // '['
    localparam logic [7:0] CH_CLOSE = 8'h5D;   // ']'
    localparam logic [7:0] CH_SPACE = 8'h20;
    localparam logic [7:0] CH_LF    = 8'h0A;
    localparam logic [7:0] CH_MINUS = 8'h2D;
    localparam logic [7:0] CH_ZERO  = 8'h30;   // Digits are offset from here

endpackage

`default_nettype wire

// File: source/matrix_store.sv
`default_nettype none

module matrix_store import matrix_pkg::*; #(
    parameter int NUM_SLOTS = 3
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire mem_wr_t   mem_wr,
    input  wire logic      dim_we,
    input  wire mat_dim_t  dim_wr,
    input  wire slot_t     dim_slot,
    input  wire mat_addr_t rd_addr,
    output elem_t          rd_data,
    output mat_dim_t       dims [NUM_SLOTS]
);

    localparam int SLOT_WORDS = MAX_DIM * MAX_DIM;

    elem_t mem [NUM_SLOTS * SLOT_WORDS];

    // Flat word index in slot major then row major order
    function automatic int word_idx(mat_addr_t a);
        return int'(a.slot) * SLOT_WORDS + int'(a.row) * MAX_DIM + int'(a.col);
    endfunction

    function automatic logic addr_ok(mat_addr_t a);
        return (a.slot < NUM_SLOTS) && (a.row < MAX_DIM) && (a.col < MAX_DIM);
    endfunction

    always_ff @(posedge clk) begin
        if (mem_wr.we && addr_ok(mem_wr.addr)) begin
            mem[word_idx(mem_wr.addr)] <= mem_wr.data;
        end
        rd_data <= addr_ok(rd_addr) ? mem[word_idx(rd_addr)] : '0;  // One-cycle read
    end

    // Per-slot dimensions that reset to empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                dims[s] <= '0;
            end
        end else if (dim_we && (dim_slot < NUM_SLOTS)) begin
            dims[dim_slot] <= dim_wr;
        end
    end

endmodule

`default_nettype wire

// File: entry/entry_ctrl.sv
`default_nettype none

module entry_ctrl import matrix_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  entry_start,
    input  wire slot_t entry_slot,
    input  wire elem_t num,
    input  wire logic  num_valid,
    output mem_wr_t    mem_wr,
    output logic       dim_we,
    output mat_dim_t   dim_wr,
    output logic       entry_done,
    output logic       entry_error
);

    typedef logic [4:0] cnt_t;  // Up to MAX_DIM * MAX_DIM

    logic     active;           // Entry in progress
    logic     have_m;
    logic     dims_ok;          // Dimensions accepted and elements follow
    slot_t    slot_q;
    dim_t     m_q;
    mat_dim_t dim_q;
    cnt_t     count;
    cnt_t     total;
    logic     in_range;

    assign in_range = (num > 0) && (num <= elem_t'(MAX_DIM));

    // Second dimension goes straight to the store
    assign dim_we = active && num_valid && !dims_ok && have_m && in_range;
    assign dim_wr = '{m: m_q, n: dim_t'(num)};

    // Element count split into row and column
    always_comb begin
        mem_wr.addr.slot = slot_q;
        mem_wr.addr.row  = dim_t'(count / cnt_t'(dim_q.n));
        mem_wr.addr.col  = dim_t'(count % cnt_t'(dim_q.n));
        mem_wr.data      = num;
        mem_wr.we        = active && dims_ok && num_valid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            have_m      <= 1'b0;
            dims_ok     <= 1'b0;
            slot_q      <= '0;
            m_q         <= '0;
            dim_q       <= '0;
            count       <= '0;
            total       <= '0;
            entry_done  <= 1'b0;
            entry_error <= 1'b0;
        end else begin
            entry_done  <= 1'b0;
            entry_error <= 1'b0;
            if (entry_start) begin
                active  <= 1'b1;
                slot_q  <= entry_slot;
                have_m  <= 1'b0;
                dims_ok <= 1'b0;
                count   <= '0;
            end else if (active && num_valid) begin
                if (!dims_ok) begin
                    if (!in_range) begin
                        entry_error <= 1'b1;    // Start the pair over
                        have_m      <= 1'b0;
                    end else if (!have_m) begin
                        m_q    <= dim_t'(num);
                        have_m <= 1'b1;
                    end else begin
                        dim_q   <= dim_wr;
                        total   <= cnt_t'(m_q) * cnt_t'(dim_wr.n);
                        dims_ok <= 1'b1;
                    end
                end else begin
                    count <= count + 5'd1;
                    if (count + 5'd1 == total) begin
                        entry_done <= 1'b1;
                        active     <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: calc/op_check.sv
`default_nettype none

module op_check import matrix_pkg::*; import calc_pkg::*; #(
    parameter int NUM_SLOTS = 3
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     check_req,
    input  wire opcode_t  opcode,
    input  wire slot_t    slot_a,
    input  wire slot_t    slot_b,
    input  wire mat_dim_t dims [NUM_SLOTS],
    output logic          check_valid,
    output logic          check_invalid
);

    mat_dim_t dim_a;
    mat_dim_t dim_b;
    logic     pass;

    always_comb begin
        dim_a = (slot_a < NUM_SLOTS) ? dims[slot_a] : '0;   // Missing slot reads empty
        dim_b = (slot_b < NUM_SLOTS) ? dims[slot_b] : '0;
        case (opcode)
            op_add, op_sub: pass = (dim_a == dim_b) && (dim_a.m != '0);
            op_mul:         pass = (dim_a.n == dim_b.m) && (dim_a.m != '0) && (dim_b.m != '0);
            op_sca, op_tra: pass = (dim_a.m != '0);
            default:        pass = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_valid   <= 1'b0;
            check_invalid <= 1'b0;
        end else begin
            check_valid   <= check_req && pass;
            check_invalid <= check_req && !pass;
        end
    end

endmodule

`default_nettype wire

// File: print/matrix_printer.sv
`default_nettype none

module matrix_printer import matrix_pkg::*; import calc_pkg::*; #(
    parameter int NUM_SLOTS = 3
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     print_req,
    input  wire slot_t    print_slot,
    input  wire mat_dim_t dims [NUM_SLOTS],
    input  wire elem_t    rd_data,
    input  wire logic     tx_busy,
    output mat_addr_t     rd_addr,
    output logic [7:0]    tx_data,
    output logic          tx_start,
    output logic          print_done
);

    typedef enum logic [3:0] {
        S_IDLE, S_OPEN, S_READ, S_LATCH, S_CONV, S_SIGN,
        S_DIGIT, S_SEP, S_CLOSE, S_LF, S_DONE
    } state_t;

    state_t     state;
    slot_t      slot_q;
    mat_dim_t   dim_q;
    dim_t       row;
    dim_t       col;
    logic [2:0] conv_cnt;
    logic [2:0] send_idx;       // Next digit to send, highest first
    logic       neg;
    logic [15:0] mag;
    logic [3:0] digits [5];     // Ones digit at index 0
    logic       can_send;
    logic       last_col;
    logic       last_row;

    // One byte per busy-free gap and never back to back
    assign can_send = !tx_busy && !tx_start;
    assign last_col = (col == dim_q.n - 3'd1);
    assign last_row = (row == dim_q.m - 3'd1);
    assign rd_addr  = '{slot: slot_q, row: row, col: col};

    // --------------------------------------------------
    // Element datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            S_LATCH: begin
                neg <= rd_data[15];
                mag <= rd_data[15] ? 16'(-rd_data) : 16'(rd_data);
            end
            S_CONV: begin
                digits[conv_cnt] <= 4'(mag % 16'd10);
                mag              <= mag / 16'd10;
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Byte sequencer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            slot_q     <= '0;
            dim_q      <= '0;
            row        <= '0;
            col        <= '0;
            conv_cnt   <= '0;
            send_idx   <= '0;
            tx_data    <= '0;
            tx_start   <= 1'b0;
            print_done <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            print_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (print_req) begin
                        slot_q <= print_slot;
                        dim_q  <= (print_slot < NUM_SLOTS) ? dims[print_slot] : '0;
                        row    <= '0;
                        col    <= '0;
                        state  <= S_OPEN;
                    end
                end
                S_OPEN: begin
                    if (can_send) begin
                        tx_data  <= CH_OPEN;
                        tx_start <= 1'b1;
                        state    <= (dim_q.m == '0) ? S_CLOSE : S_READ;  // Empty prints []
                    end
                end
                S_READ: state <= S_LATCH;   // Store answers next cycle
                S_LATCH: begin
                    conv_cnt <= '0;
                    send_idx <= '0;
                    state    <= S_CONV;
                end
                S_CONV: begin
                    if (mag % 16'd10 != '0) begin
                        send_idx <= conv_cnt;   // Highest nonzero digit wins
                    end
                    conv_cnt <= conv_cnt + 3'd1;
                    if (conv_cnt == 3'd4) begin
                        state <= neg ? S_SIGN : S_DIGIT;
                    end
                end
                S_SIGN: begin
                    if (can_send) begin
                        tx_data  <= CH_MINUS;
                        tx_start <= 1'b1;
                        state    <= S_DIGIT;
                    end
                end
                S_DIGIT: begin
                    if (can_send) begin
                        tx_data  <= CH_ZERO + 8'(digits[send_idx]);
                        tx_start <= 1'b1;
                        if (send_idx == '0) begin
                            state <= S_SEP;
                        end else begin
                            send_idx <= send_idx - 3'd1;
                        end
                    end
                end
                S_SEP: begin
                    if (last_col && last_row) begin
                        state <= S_CLOSE;
                    end else if (can_send) begin
                        tx_start <= 1'b1;
                        state    <= S_READ;
                        if (!last_col) begin
                            tx_data <= CH_SPACE;
                            col     <= col + 3'd1;
                        end else begin
                            tx_data <= CH_LF;   // Next row
                            row     <= row + 3'd1;
                            col     <= '0;
                        end
                    end
                end
                S_CLOSE: begin
                    if (can_send) begin
                        tx_data  <= CH_CLOSE;
                        tx_start <= 1'b1;
                        state    <= S_LF;
                    end
                end
                S_LF: begin
                    if (can_send) begin
                        tx_data  <= CH_LF;
                        tx_start <= 1'b1;
                        state    <= S_DONE;
                    end
                end
                S_DONE: begin
                    print_done <= 1'b1;
                    state      <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/matrix_calc_top.sv
`default_nettype none

module matrix_calc_top import matrix_pkg::*; import calc_pkg::*; #(
    parameter int NUM_SLOTS = 3
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    // Matrix entry
    input  wire logic    entry_start,
    input  wire slot_t   entry_slot,
    input  wire elem_t   num,
    input  wire logic    num_valid,
    output logic         entry_done,
    output logic         entry_error,
    // Operand check
    input  wire logic    check_req,
    input  wire opcode_t opcode,
    input  wire slot_t   slot_a,
    input  wire slot_t   slot_b,
    output logic         check_valid,
    output logic         check_invalid,
    // Print to byte transmitter
    input  wire logic    print_req,
    input  wire slot_t   print_slot,
    input  wire logic    tx_busy,
    output logic [7:0]   tx_data,
    output logic         tx_start,
    output logic         print_done
);

    mem_wr_t   mem_wr;
    logic      dim_we;
    mat_dim_t  dim_wr;
    mat_addr_t rd_addr;
    elem_t     rd_data;
    mat_dim_t  dims [NUM_SLOTS];

    entry_ctrl entry_ctrl_inst (
        .clk, .rst_n, .entry_start, .entry_slot, .num, .num_valid,
        .mem_wr, .dim_we, .dim_wr, .entry_done, .entry_error
    );

    // Dimension writes go to the slot being entered
    matrix_store #(.NUM_SLOTS(NUM_SLOTS)) matrix_store_inst (
        .clk, .rst_n, .mem_wr, .dim_we, .dim_wr,
        .dim_slot (mem_wr.addr.slot),
        .rd_addr, .rd_data, .dims
    );

    op_check #(.NUM_SLOTS(NUM_SLOTS)) op_check_inst (
        .clk, .rst_n, .check_req, .opcode, .slot_a, .slot_b, .dims,
        .check_valid, .check_invalid
    );

    matrix_printer #(.NUM_SLOTS(NUM_SLOTS)) matrix_printer_inst (
        .clk, .rst_n, .print_req, .print_slot, .dims, .rd_data, .tx_busy,
        .rd_addr, .tx_data, .tx_start, .print_done
    );

endmodule

`default_nettype wire

// File: testbench/tb_matrix_calc.sv
`default_nettype none

module tb_matrix_calc
    import matrix_pkg::*;
    import calc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       entry_start;
    slot_t      entry_slot;
    elem_t      num;
    logic       num_valid;
    logic       entry_done;
    logic       entry_error;
    logic       check_req;
    opcode_t    opcode;
    slot_t      slot_a;
    slot_t      slot_b;
    logic       check_valid;
    logic       check_invalid;
    logic       print_req;
    slot_t      print_slot;
    logic       tx_busy;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       print_done;

    // Reference copy of the slots
    mat_dim_t model_dims [4];
    int       model_mem [4][MAX_DIM][MAX_DIM];
    logic     ent_active;
    logic     ent_have_m;
    logic     ent_dims_ok;
    int       ent_slot;
    int       ent_m;
    int       ent_n;
    int       ent_count;

    int seed = 32'hb8940009;
    int cycles = 0;
    int cycle_limit = 100;

    matrix_calc_top #(.NUM_SLOTS(3)) matrix_calc_top_inst (
        .clk, .rst_n, .entry_start, .entry_slot, .num, .num_valid,
        .entry_done, .entry_error, .check_req, .opcode, .slot_a, .slot_b,
        .check_valid, .check_invalid, .print_req, .print_slot, .tx_busy,
        .tx_data, .tx_start, .print_done
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // Failure reporting and compare tasks
    // --------------------------------------------------
    task automatic report_failure(string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic check_byte(string name, logic [7:0] expected, logic [7:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected 8'h%02h, actual 8'h%02h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_dim(string name, mat_dim_t expected, mat_dim_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected %0dx%0d, actual %0dx%0d",
                                     name, expected.m, expected.n, actual.m, actual.n));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout: run still busy after %0d clock cycles",
                                     cycles));
        end
    end

    // --------------------------------------------------
    // Stimulus tasks start and end on a falling edge
    // --------------------------------------------------
    task automatic send_value(int v, string name);
        logic exp_err;
        logic exp_done;
        exp_err  = 1'b0;
        exp_done = 1'b0;
        if (ent_active && !ent_dims_ok) begin
            if (v < 1 || v > MAX_DIM) begin
                exp_err    = 1'b1;          // Pair starts over
                ent_have_m = 1'b0;
            end else if (!ent_have_m) begin
                ent_m      = v;
                ent_have_m = 1'b1;
            end else begin
                ent_n       = v;
                ent_dims_ok = 1'b1;
                model_dims[ent_slot] = '{m: dim_t'(ent_m), n: dim_t'(ent_n)};
            end
        end else if (ent_active) begin
            model_mem[ent_slot][ent_count / ent_n][ent_count % ent_n] = v;
            ent_count++;
            if (ent_count == ent_m * ent_n) begin
                exp_done   = 1'b1;
                ent_active = 1'b0;
            end
        end
        num       = elem_t'(v);
        num_valid = 1'b1;
        @(negedge clk);
        num_valid = 1'b0;
        check_bit({name, " entry_error"}, exp_err, entry_error);
        check_bit({name, " entry_done"}, exp_done, entry_done);
        if (exp_done) begin
            check_dim({name, " dims"}, model_dims[ent_slot],
                      matrix_calc_top_inst.dims[ent_slot]);
        end
    endtask

    task automatic run_entry(int slot, int m, int n, string name);
        ent_active  = 1'b1;
        ent_have_m  = 1'b0;
        ent_dims_ok = 1'b0;
        ent_slot    = slot;
        ent_count   = 0;
        entry_slot  = slot_t'(slot);
        entry_start = 1'b1;
        @(negedge clk);
        entry_start = 1'b0;
        send_value(m, {name, " m"});
        send_value(n, {name, " n"});
    endtask

    task automatic run_check(int op, int a, int b, int expected, string name);
        opcode    = opcode_t'(3'(op));
        slot_a    = slot_t'(a);
        slot_b    = slot_t'(b);
        check_req = 1'b1;
        @(negedge clk);
        check_req = 1'b0;
        check_bit({name, " check_valid"}, expected != 0, check_valid);
        check_bit({name, " check_invalid"}, expected == 0, check_invalid);
    endtask

    // Expected text of one slot with LF between rows and a space between elements
    function automatic string expected_text(int slot);
        string s;
        int    m;
        int    n;
        m = int'(model_dims[slot].m);
        n = int'(model_dims[slot].n);
        s = "[";
        for (int r = 0; r < m; r++) begin
            for (int c = 0; c < n; c++) begin
                s = {s, $sformatf("%0d", model_mem[slot][r][c])};
                if (c < n - 1) begin
                    s = {s, " "};
                end else if (r < m - 1) begin
                    s = {s, "\n"};
                end
            end
        end
        return {s, "]\n"};
    endfunction

    task automatic run_print(int slot, string name);
        string expected;
        int    idx;
        int    busy_left;
        logic  prev_start;
        logic  finished;
        expected   = expected_text(slot);
        idx        = 0;
        busy_left  = 0;
        prev_start = 1'b0;
        finished   = 1'b0;
        print_slot = slot_t'(slot);
        print_req  = 1'b1;
        @(negedge clk);
        print_req = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (tx_start) begin
                if (tx_busy) begin
                    report_failure({name, ": tx_start came while tx_busy was high"});
                end
                if (prev_start) begin
                    report_failure({name, ": tx_start pulsed on two adjacent cycles"});
                end
                if (idx >= expected.len()) begin
                    report_failure({name, ": more bytes sent than the matrix text holds"});
                end
                check_byte($sformatf("%s byte %0d", name, idx), expected[idx], tx_data);
                idx++;
                busy_left = $unsigned($random(seed)) % 4;  // 0 to 3 busy cycles
            end else if (busy_left > 0) begin
                busy_left--;
            end
            tx_busy = (busy_left > 0);
            if (print_done) begin
                check_bit({name, " print_done after final LF"}, 1'b1, prev_start);
                if (idx != expected.len()) begin
                    report_failure($sformatf("%s: print_done after %0d of %0d bytes",
                                             name, idx, expected.len()));
                end
                finished = 1'b1;
            end
            prev_start = tx_start;
        end
    endtask

    task automatic skip_line(int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != -1 && ch != "\n") begin
            ch = $fgetc(fd);
        end
    endtask

    // Counts command lines and skips comment lines
    function automatic int count_commands(int fd);
        int   ch;
        int   lines;
        logic at_start;
        lines    = 0;
        at_start = 1'b1;
        ch       = $fgetc(fd);
        while (ch != -1) begin
            if (at_start && ch != "#" && ch != "\n") begin
                lines++;
            end
            at_start = (ch == "\n");
            ch = $fgetc(fd);
        end
        return lines;
    endfunction

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int         fd;
        int         rc;
        int         cmd_no;
        int         arg [4];
        logic [7:0] cmd;
        string      name;
        rst_n       = 1'b0;
        entry_start = 1'b0;
        entry_slot  = '0;
        num         = '0;
        num_valid   = 1'b0;
        check_req   = 1'b0;
        opcode      = op_add;
        slot_a      = '0;
        slot_b      = '0;
        print_req   = 1'b0;
        print_slot  = '0;
        tx_busy     = 1'b0;
        ent_active  = 1'b0;
        for (int s = 0; s < 4; s++) begin
            model_dims[s] = '0;
        end

        fd = $fopen("testbench/testdata_matrix.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open testbench/testdata_matrix.txt");
        end
        cycle_limit = 200 * count_commands(fd) + 100;
        $fclose(fd);
        fd = $fopen("testbench/testdata_matrix.txt", "r");

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset entry_done", 1'b0, entry_done);
        check_bit("reset entry_error", 1'b0, entry_error);
        check_bit("reset tx_start", 1'b0, tx_start);
        check_bit("reset print_done", 1'b0, print_done);
        check_bit("reset check_valid", 1'b0, check_valid);
        check_bit("reset check_invalid", 1'b0, check_invalid);
        for (int s = 0; s < 3; s++) begin
            check_dim($sformatf("reset dims slot %0d", s), '0, matrix_calc_top_inst.dims[s]);
        end

        cmd_no = 0;
        rc = $fscanf(fd, " %c", cmd);
        while (rc == 1) begin
            if (cmd == "#") begin
                skip_line(fd);
            end else begin
                cmd_no++;
                name = $sformatf("cmd %0d %s", cmd_no, cmd);
                case (cmd)
                    "D": rc = $fscanf(fd, "%d %d %d", arg[0], arg[1], arg[2]);
                    "V": rc = $fscanf(fd, "%d", arg[0]);
                    "C": rc = $fscanf(fd, "%d %d %d %d", arg[0], arg[1], arg[2], arg[3]);
                    "P": rc = $fscanf(fd, "%d", arg[0]);
                    default: report_failure({name, ": unknown command in data file"});
                endcase
                if (rc < 1) begin
                    report_failure({name, ": missing fields in data file"});
                end
                case (cmd)
                    "D": run_entry(arg[0], arg[1], arg[2], name);
                    "V": send_value(arg[0], name);
                    "C": run_check(arg[0], arg[1], arg[2], arg[3], name);
                    default: run_print(arg[0], name);
                endcase
            end
            rc = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/matrix_pkg.sv
common/calc_pkg.sv
source/matrix_store.sv
entry/entry_ctrl.sv
calc/op_check.sv
print/matrix_printer.sv
source/matrix_calc_top.sv
testbench/tb_matrix_calc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the matrix calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_matrix_calc -f build.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: testbench/testdata_matrix.txt
# D slot m n | V value | C opcode slot_a slot_b expected(1 legal, 0 not) | P slot
# Opcodes: 0 add, 1 sub, 2 mul, 3 sca, 4 tra, 5 not defined
D 0 2 3
V 5
V -12
V 0
V 32767
V -32767
V 100
D 1 0 6
V 3
V 1
V 7
V 0
V -8
C 0 0 1 0
C 1 0 0 1
C 2 0 1 1
C 2 1 0 0
C 3 2 0 0
C 4 1 0 1
C 3 3 0 0
C 5 0 0 0
P 0
P 1
P 2
V 9
